//--- src.f
hdl/tnn_pkg.sv
hdl/sample_dispatch.sv
hdl/hidden_layer.sv
hdl/class_vote.sv
hdl/har_tnn_classifier.sv
tests/tb_har_tnn_assertions.sv
tests/tb_har_tnn.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_har_tnn \
    --Mdir obj_dir \
    -o tb_har_tnn \
    -f src.f

./obj_dir/tb_har_tnn

//--- tests/tb_har_tnn.sv
`timescale 1ns/1ps
`default_nettype none

module tb_har_tnn import tnn_pkg::*; ();

    localparam int hold_cycles = 30;
    localparam int cycles_per_sample = 40;
    localparam int sample_total = 2 + 1 + 64 + 6 + 8 + 4;
    localparam int watchdog_cycles = sample_total * cycles_per_sample + hold_cycles;
    localparam int drain_limit = 200;

    logic    clk = 1'b0;
    logic    rst;
    logic    in_valid;
    sample_t in_sample;
    logic    in_credit;
    logic    out_credit = 1'b0;
    logic    out_valid;
    result_t out_result;

    result_t     expected_q [$];
    string       test_name;
    logic [15:0] lfsr_state;
    logic        hold;
    int          sent;
    int          returned = 0;
    int          results = 0;
    int          owed = 0;
    logic        hold_q = 1'b0;

    har_tnn_classifier u_har_tnn_classifier (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    always #10 clk = ~clk;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    function automatic logic random_bit();
        logic bit_out;
        bit_out = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        return bit_out;
    endfunction

    function automatic feature_vec_t random_features();
        feature_vec_t feat;
        for (int f = 0; f < feat_cnt; f++) begin
            for (int b = 0; b < feat_bits; b++) begin
                feat[f][b] = random_bit();
            end
        end
        return feat;
    endfunction

    // ternary network evaluated straight from the weight tables.
    function automatic logic [class_bits-1:0] predict_class(input feature_vec_t feat);
        logic [hidden_cnt-1:0] hid;
        int                    pos_sum;
        int                    neg_sum;
        int                    votes;
        int                    score;
        int                    best_score;
        int                    best_class;
        for (int n = 0; n < hidden_cnt; n++) begin
            pos_sum = 0;
            neg_sum = 0;
            for (int f = 0; f < feat_cnt; f++) begin
                if (hidden_pos_mask[n][f]) begin
                    pos_sum += int'(feat[f]);
                end
                if (hidden_neg_mask[n][f]) begin
                    neg_sum += int'(feat[f]);
                end
            end
            hid[n] = (pos_sum >= neg_sum);
        end
        best_score = -1;
        best_class = 0;
        for (int c = 0; c < class_cnt; c++) begin
            votes = 0;
            for (int k = 0; k < hidden_cnt; k++) begin
                if ((hid[k] && class_pos_mask[c][k]) || (!hid[k] && class_neg_mask[c][k])) begin
                    votes++;
                end
            end
            score = 2 * votes + int'(class_bias[c]);
            if (score > best_score) begin
                best_score = score;
                best_class = c;
            end
        end
        return class_bits'(best_class);
    endfunction

    // result checker and credit bookkeeping, sampled on the rising edge.
    always @(posedge clk) begin
        result_t exp;
        hold_q = hold;
        if (rst) begin
            owed = 0;
            returned = 0;
        end else begin
            if (in_credit) begin
                returned++;
            end
            if (out_credit) begin
                owed--;
            end
            if (out_valid) begin
                assert (expected_q.size() != 0)
                else report_error($sformatf("%s: result with no sample outstanding", test_name));
                exp = expected_q.pop_front();
                assert (out_result == exp)
                else report_error($sformatf(
                    "Fail %s: expected tag %0d class %0d, actual tag %0d class %0d",
                    test_name, exp.tag, exp.class_id, out_result.tag, out_result.class_id));
                results++;
                owed++;
            end
        end
    end

    // downstream buffer frees one slot per cycle unless held off.
    always @(negedge clk) begin
        out_credit = !hold_q && (owed > 0);
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        report_error("timeout: the tests did not finish in the expected number of cycles");
    end

    task automatic send_sample(input logic [tag_bits-1:0] tag, input feature_vec_t feat);
        while (in_queue_depth - sent + returned <= 0) begin
            @(negedge clk);
        end
        in_valid  = 1'b1;
        in_sample = '{tag: tag, features: feat};
        expected_q.push_back('{tag: tag, class_id: predict_class(feat)});
        sent++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while ((expected_q.size() != 0 || owed != 0) && cycles < drain_limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (cycles < drain_limit)
        else report_error($sformatf("%s: the design did not go idle", test_name));
        @(negedge clk);
    endtask

    task automatic extreme_features_test();
        test_name = "extreme_features";
        send_sample(8'h01, '0);
        send_sample(8'h02, '1);
        wait_idle();
    endtask

    task automatic latency_test();
        int cycles;
        test_name = "latency";
        send_sample(8'h5A, random_features());
        cycles = 0;
        while (!out_valid && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        assert (cycles == 3)
        else report_error($sformatf("Fail %s: expected 3 cycles, actual %0d", test_name, cycles));
        assert (out_result.tag == 8'h5A)
        else report_error($sformatf("Fail %s: expected tag 90, actual %0d",
            test_name, out_result.tag));
        wait_idle();
    endtask

    task automatic streaming_test();
        test_name = "streaming";
        for (int i = 0; i < 64; i++) begin
            send_sample(tag_bits'(i + 16), random_features());
        end
        wait_idle();
    endtask

    task automatic backpressure_test();
        int r0;
        int c0;
        test_name = "backpressure";
        r0 = results;
        c0 = returned;
        hold = 1'b1;
        for (int i = 0; i < in_queue_depth + out_credit_max; i++) begin
            send_sample(tag_bits'(160 + i), random_features());
        end
        repeat (hold_cycles) begin
            @(negedge clk);
            assert (results - r0 <= out_credit_max)
            else report_error("backpressure: a result left without an output credit");
        end
        assert (results - r0 == out_credit_max)
        else report_error($sformatf("Fail %s: expected %0d results, actual %0d",
            test_name, out_credit_max, results - r0));
        assert (returned - c0 == out_credit_max)
        else report_error($sformatf("Fail %s: expected %0d in_credit pulses, actual %0d",
            test_name, out_credit_max, returned - c0));
        assert (in_queue_depth - sent + returned == 0)
        else report_error("backpressure: upstream still holds input credits with a full queue");
        hold = 1'b0;
        wait_idle();
    endtask

    task automatic credit_return_test();
        int s0;
        int r0;
        test_name = "credit_return";
        s0 = sent;
        r0 = returned;
        for (int i = 0; i < 8; i++) begin
            send_sample(tag_bits'(200 + i), random_features());
        end
        wait_idle();
        assert (returned - r0 == sent - s0)
        else report_error($sformatf("Fail %s: expected %0d in_credit pulses, actual %0d",
            test_name, sent - s0, returned - r0));
        assert (in_queue_depth - sent + returned == in_queue_depth)
        else report_error($sformatf("Fail %s: expected %0d upstream credits, actual %0d",
            test_name, in_queue_depth, in_queue_depth - sent + returned));
    endtask

    task automatic midstream_reset_test();
        test_name = "midstream_reset";
        for (int i = 0; i < 3; i++) begin
            send_sample(tag_bits'(240 + i), random_features());
        end
        @(negedge clk);
        // in-flight samples are lost, so the model forgets them too.
        rst = 1'b1;
        in_valid = 1'b0;
        hold = 1'b0;
        sent = 0;
        expected_q.delete();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (8) begin
            @(negedge clk);
            assert (!out_valid)
            else report_error("midstream_reset: a stale result appeared after reset");
        end
        send_sample(8'hEE, random_features());
        wait_idle();
    endtask

    initial begin
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_sample  = '0;
        hold       = 1'b0;
        sent       = 0;
        lfsr_state = 16'd306;
        test_name  = "reset";
        repeat (4) @(negedge clk);
        rst = 1'b0;
        extreme_features_test();
        latency_test();
        streaming_test();
        backpressure_test();
        credit_return_test();
        midstream_reset_test();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tb_har_tnn_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tb_har_tnn_assertions import tnn_pkg::*; (
    input logic                   clk,
    input logic                   rst,
    input logic                   in_valid,
    input logic                   in_credit,
    input logic                   out_valid,
    input logic [q_cnt_bits-1:0]  fill_cnt,
    input logic [credit_bits-1:0] credit_cnt,
    input logic                   pop
);

    // upstream spends a credit per sample, so the queue has room.
    a_queue_room: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> (fill_cnt != q_cnt_bits'(in_queue_depth)))
        else $error("sample arrived while the input queue was full");

    a_credit_limit: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= credit_bits'(out_credit_max))
        else $error("output credit count above the downstream buffer size");

    a_reset_quiet: assert property (@(posedge clk)
        $fell(rst) |-> (!in_credit && !out_valid))
        else $error("in_credit or out_valid high right after reset");

    // pop, execute, result.
    a_result_origin: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(pop, 3))
        else $error("result without a sample issued three cycles earlier");

endmodule

bind har_tnn_classifier tb_har_tnn_assertions u_har_tnn_assertions (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .fill_cnt   (u_sample_dispatch.fill_cnt),
    .credit_cnt (u_sample_dispatch.credit_cnt),
    .pop        (u_sample_dispatch.pop)
);

`default_nettype wire

//--- hdl/har_tnn_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module har_tnn_classifier import tnn_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  sample_t in_sample,
    output logic    in_credit,
    input  logic    out_credit,
    output logic    out_valid,
    output result_t out_result
);

    dispatch_stage_t issue;
    hidden_stage_t   hidden;

    // queue and credit gate.
    sample_dispatch u_sample_dispatch (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .issue      (issue)
    );

    // execute stage.
    hidden_layer u_hidden_layer (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue),
        .hidden (hidden)
    );

    // result stage.
    class_vote u_class_vote (
        .clk        (clk),
        .rst        (rst),
        .hidden     (hidden),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

`default_nettype wire

//--- hdl/class_vote.sv
`timescale 1ns/1ps
`default_nettype none

module class_vote import tnn_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  hidden_stage_t hidden,
    output logic          out_valid,
    output result_t       out_result
);

    logic [score_bits-1:0] score [class_cnt];
    logic [score_bits-1:0] best_score;
    logic [class_bits-1:0] best_idx;
    logic [tag_bits-1:0]   result_tag;
    logic [class_bits-1:0] result_class;
    logic                  result_valid;

    for (genvar c = 0; c < class_cnt; c++) begin : g_class
        hidden_vec_t          agree;
        logic [vote_bits-1:0] votes;

        // set under the positive mask or clear under the negative one.
        assign agree = (hidden.neurons & class_pos_mask[c])
                     | (~hidden.neurons & class_neg_mask[c]);

        always_comb begin
            votes = '0;
            for (int k = 0; k < hidden_cnt; k++) begin
                votes = votes + vote_bits'(agree[k]);
            end
        end

        assign score[c] = score_bits'({votes, 1'b0}) + score_bits'(class_bias[c]);
    end

    // strict compare keeps the lowest index on a tie.
    always_comb begin
        best_score = score[0];
        best_idx   = '0;
        for (int c = 1; c < class_cnt; c++) begin
            if (score[c] > best_score) begin
                best_score = score[c];
                best_idx   = class_bits'(c);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= hidden.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (hidden.valid) begin
            result_tag   <= hidden.tag;
            result_class <= best_idx;
        end
    end

    assign out_valid  = result_valid;
    assign out_result = '{tag: result_tag, class_id: result_class};

endmodule

`default_nettype wire

//--- hdl/hidden_layer.sv
`timescale 1ns/1ps
`default_nettype none

module hidden_layer import tnn_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  dispatch_stage_t issue,
    output hidden_stage_t   hidden
);

    hidden_vec_t         fire;
    logic                stage_valid;
    logic [tag_bits-1:0] stage_tag;
    hidden_vec_t         stage_neurons;

    for (genvar n = 0; n < hidden_cnt; n++) begin : g_neuron
        logic [sum_bits-1:0] pos_sum;
        logic [sum_bits-1:0] neg_sum;

        always_comb begin
            pos_sum = '0;
            neg_sum = '0;
            for (int f = 0; f < feat_cnt; f++) begin
                if (hidden_pos_mask[n][f]) begin
                    pos_sum = pos_sum + sum_bits'(issue.features[f]);
                end
                if (hidden_neg_mask[n][f]) begin
                    neg_sum = neg_sum + sum_bits'(issue.features[f]);
                end
            end
        end

        // ties fire.
        assign fire[n] = (pos_sum >= neg_sum);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            stage_tag     <= issue.tag;
            stage_neurons <= fire;
        end
    end

    assign hidden = '{valid: stage_valid, tag: stage_tag, neurons: stage_neurons};

endmodule

`default_nettype wire

//--- hdl/sample_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module sample_dispatch import tnn_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  sample_t         in_sample,
    output logic            in_credit,
    input  logic            out_credit,
    output dispatch_stage_t issue
);

    sample_t                queue_mem [in_queue_depth];
    logic [q_ptr_bits-1:0]  wr_ptr;
    logic [q_ptr_bits-1:0]  rd_ptr;
    logic [q_cnt_bits-1:0]  fill_cnt;
    logic [credit_bits-1:0] credit_cnt;
    logic                   q_full;
    logic                   q_empty;
    logic                   push;
    logic                   pop;
    logic                   issue_valid;
    sample_t                issue_sample;

    assign q_full  = (fill_cnt == q_cnt_bits'(in_queue_depth));
    assign q_empty = (fill_cnt == '0);

    // a write into a full queue is refused.
    assign push = in_valid && !q_full;

    // head leaves only while a downstream slot is held.
    assign pop = !q_empty && (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            queue_mem[wr_ptr] <= in_sample;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_cnt <= '0;
        end else begin
            case ({push, pop})
                2'b10:   fill_cnt <= fill_cnt + 1'b1;
                2'b01:   fill_cnt <= fill_cnt - 1'b1;
                default: fill_cnt <= fill_cnt;
            endcase
        end
    end

    // returned and spent on one edge cancels out.
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= credit_bits'(out_credit_max);
        end else begin
            case ({out_credit, pop})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
            in_credit   <= 1'b0;
        end else begin
            issue_valid <= pop;
            in_credit   <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            issue_sample <= queue_mem[rd_ptr];
        end
    end

    assign issue = '{
        valid:    issue_valid,
        tag:      issue_sample.tag,
        features: issue_sample.features
    };

endmodule

`default_nettype wire

//--- hdl/tnn_pkg.sv
`default_nettype none

package tnn_pkg;

    // network sizes.
    localparam int feat_cnt = 12;
    localparam int feat_bits = 4;
    localparam int hidden_cnt = 40;
    localparam int class_cnt = 6;
    localparam int class_bits = 3;
    localparam int tag_bits = 8;
    localparam int sum_bits = 8;
    localparam int score_bits = 7;
    localparam int vote_bits = $clog2(hidden_cnt + 1);

    // flow control.
    localparam int in_queue_depth = 4;
    localparam int out_credit_max = 2;
    localparam int q_ptr_bits = $clog2(in_queue_depth);
    localparam int q_cnt_bits = $clog2(in_queue_depth + 1);
    localparam int credit_bits = $clog2(out_credit_max + 1);

    // hidden neuron masks, bit f selects feature f.
    localparam logic [feat_cnt-1:0] hidden_pos_mask [0:hidden_cnt-1] = '{
        12'hD42, 12'h32A, 12'h000, 12'h00C, 12'h1C8,
        12'h000, 12'hA0C, 12'h946, 12'h020, 12'hA23,
        12'h308, 12'h08C, 12'hAF0, 12'h483, 12'h4C5,
        12'h00A, 12'h109, 12'h101, 12'hA28, 12'hD61,
        12'hB10, 12'h0C0, 12'h420, 12'hC84, 12'hAC8,
        12'h25A, 12'h444, 12'h20A, 12'h0A0, 12'h059,
        12'h109, 12'h10B, 12'h006, 12'h0D2, 12'hC92,
        12'h612, 12'h00A, 12'h0C0, 12'h110, 12'h489
    };

    localparam logic [feat_cnt-1:0] hidden_neg_mask [0:hidden_cnt-1] = '{
        12'h299, 12'h084, 12'h000, 12'hA31, 12'hE00,
        12'h000, 12'h102, 12'h2B9, 12'h40E, 12'h4CC,
        12'h036, 12'hC00, 12'h001, 12'hA28, 12'h008,
        12'hC21, 12'hE00, 12'hA42, 12'h101, 12'h08E,
        12'h402, 12'h208, 12'h390, 12'h211, 12'h102,
        12'h885, 12'h09A, 12'h050, 12'hB01, 12'h886,
        12'h206, 12'h0F0, 12'hE38, 12'h82D, 12'h049,
        12'h941, 12'h431, 12'h225, 12'h801, 12'hB10
    };

    // class masks, bit k selects hidden neuron k.
    localparam logic [hidden_cnt-1:0] class_pos_mask [0:class_cnt-1] = '{
        40'h04_0312_2440,
        40'h04_0114_5440,
        40'h01_0B06_0442,
        40'h05_8123_0011,
        40'h01_0000_5920,
        40'h81_0C02_2809
    };

    localparam logic [hidden_cnt-1:0] class_neg_mask [0:class_cnt-1] = '{
        40'h11_5441_4000,
        40'h1A_A041_0820,
        40'h02_0460_2001,
        40'h40_2004_0802,
        40'h48_A204_0010,
        40'h48_2084_0000
    };

    localparam logic [2:0] class_bias [0:class_cnt-1] = '{
        3'd1, 3'd0, 3'd2, 3'd3, 3'd4, 3'd3
    };

    // feature 0 sits in the top nibble.
    typedef logic [0:feat_cnt-1][feat_bits-1:0] feature_vec_t;

    typedef logic [hidden_cnt-1:0] hidden_vec_t;

    typedef struct packed {
        logic [tag_bits-1:0] tag;
        feature_vec_t        features;
    } sample_t;

    typedef struct packed {
        logic                valid;
        logic [tag_bits-1:0] tag;
        feature_vec_t        features;
    } dispatch_stage_t;

    typedef struct packed {
        logic                valid;
        logic [tag_bits-1:0] tag;
        hidden_vec_t         neurons;
    } hidden_stage_t;

    typedef struct packed {
        logic [tag_bits-1:0]   tag;
        logic [class_bits-1:0] class_id;
    } result_t;

endpackage

`default_nettype wire
